// File: Bender.yml
package:
  name: bpi_flash_led

sources:
  - common/bpi_pkg.sv
  - bpi/bpi_cycle_fsm.sv
  - bpi/bpi_port.sv
  - display/led_channel.sv
  - display/led_sequencer.sv
  - design/bpi_top.sv
  - target: test
    files:
      - tb/bpi_checker.sv
      - tb/bpi_top_sva.sv
      - tb/tb_bpi_top.sv

// File: bpi/bpi_cycle_fsm.sv
`timescale 1ns/1ns

module bpi_cycle_fsm (
  input  logic CLK,
  input  logic RST,
  input  logic execute_i,
  input  logic read_i,
  input  logic write_i,
  output logic capture_o,
  output logic busy_o,
  output logic load_o,
  output logic ce_o,
  output logic latch_o,
  output logic we_o,
  output logic oe_o
);
  import bpi_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_latch,
    st_access,
    st_recover
  } state_t;

  state_t             state_q;
  logic [PHASE_W-1:0] phase_q;
  logic               op_active;

  // Standby and code 3 leave both bits low
  assign op_active = read_i | write_i;

  ////////////////////////////////////////
  // State and phase counter
  ////////////////////////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q <= st_idle;
      phase_q <= '0;
    end else begin
      case (state_q)
        st_idle: begin
          phase_q <= '0;
          if (execute_i) state_q <= st_latch;   // Op bits captured on this edge
        end
        st_latch: begin
          if (!op_active) begin
            state_q <= st_idle;                 // Standby takes one busy cycle
          end else if (phase_q == PHASE_W'(LATCH_CYCLES - 1)) begin
            state_q <= st_access;
            phase_q <= '0;
          end else begin
            phase_q <= phase_q + 1'b1;
          end
        end
        st_access: begin
          if (phase_q == PHASE_W'(ACCESS_CYCLES - 1)) begin
            state_q <= st_recover;
            phase_q <= '0;
          end else begin
            phase_q <= phase_q + 1'b1;
          end
        end
        default: begin
          if (phase_q == PHASE_W'(RECOVER_CYCLES - 1)) begin
            state_q <= st_idle;
            phase_q <= '0;
          end else begin
            phase_q <= phase_q + 1'b1;
          end
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Strobe decode
  ////////////////////////////////////////
  assign capture_o = (state_q == st_idle) && execute_i;
  assign busy_o    = (state_q != st_idle);
  assign latch_o   = (state_q == st_latch) && op_active;
  assign ce_o      = latch_o || (state_q == st_access);
  assign we_o      = (state_q == st_access) && write_i;
  assign oe_o      = (state_q == st_access) && read_i;

  // Read data valid on the last access cycle
  assign load_o    = oe_o && (phase_q == PHASE_W'(ACCESS_CYCLES - 1));

endmodule

// File: bpi/bpi_port.sv
`timescale 1ns/1ns

module bpi_port (
  input  logic                        CLK,
  input  logic [bpi_pkg::ADDR_W-1:0]  addr_i,
  input  logic [bpi_pkg::DATA_W-1:0]  cmd_data_i,
  input  logic [bpi_pkg::OP_W-1:0]    op_i,
  input  logic                        execute_i,
  input  logic [bpi_pkg::ADDR_W-1:0]  al_addr_i,
  input  logic [bpi_pkg::DATA_W-1:0]  al_cmd_data_i,
  input  logic [bpi_pkg::OP_W-1:0]    al_op_i,
  input  logic                        al_execute_i,
  input  logic                        al_ena_i,
  input  logic                        bpi_active_i,
  input  logic [bpi_pkg::DATA_W-1:0]  status_i,
  input  logic [bpi_pkg::DATA_W-1:0]  leds_i,
  input  logic                        display_i,
  input  logic                        capture_i,
  input  logic                        ce_i,
  input  logic                        latch_i,
  input  logic                        we_i,
  input  logic                        oe_i,
  output logic                        execute_o,
  output logic                        read_o,
  output logic                        write_o,
  output logic [bpi_pkg::DATA_W-1:0]  data_o,
  output logic [bpi_pkg::ADDR_W-1:0]  bpi_ad_o,
  output logic                        fcs_b_o,
  output logic                        foe_b_o,
  output logic                        fwe_b_o,
  output logic                        flatch_b_o,
  inout  wire  [bpi_pkg::DATA_W-1:0]  cfg_dat_io
);
  import bpi_pkg::*;

  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] data_q;
  logic [OP_W-1:0]   op_sel;
  logic [DATA_W-1:0] show_val;
  logic [DATA_W-1:0] pin_val;

  // Auto-load set wins when enabled
  assign op_sel    = al_ena_i ? al_op_i : op_i;
  assign execute_o = al_ena_i ? al_execute_i : execute_i;

  always_ff @(posedge CLK) begin
    if (capture_i) begin
      addr_q  <= al_ena_i ? al_addr_i : addr_i;
      data_q  <= al_ena_i ? al_cmd_data_i : cmd_data_i;
      write_o <= (op_sel == OP_WRITE);
      read_o  <= (op_sel == OP_READ);      // Code 3 clears both
    end
  end

  ////////////////////////////////////////
  // Pins
  ////////////////////////////////////////
  assign show_val = display_i ? leds_i : status_i;
  assign pin_val  = (ce_i || bpi_active_i || al_ena_i) ? data_q : show_val;

  assign cfg_dat_io = oe_i ? 'z : pin_val;   // Flash drives during reads
  assign data_o     = cfg_dat_io;
  assign bpi_ad_o   = addr_q;

  assign fcs_b_o    = ~ce_i;
  assign foe_b_o    = ~oe_i;
  assign fwe_b_o    = ~we_i;
  assign flatch_b_o = ~latch_i;

endmodule

// File: common/bpi_pkg.sv
package bpi_pkg;

  ////////////////////////////////////////
  // Flash bus widths and operation codes
  ////////////////////////////////////////
  localparam int ADDR_W = 23;
  localparam int DATA_W = 16;          // Also the LED channel count
  localparam int OP_W   = 2;

  localparam logic [OP_W-1:0] OP_STANDBY = 2'd0;
  localparam logic [OP_W-1:0] OP_WRITE   = 2'd1;
  localparam logic [OP_W-1:0] OP_READ    = 2'd2;

  // Bus-cycle lengths in CLK cycles
  localparam int LATCH_CYCLES   = 2;
  localparam int ACCESS_CYCLES  = 4;
  localparam int RECOVER_CYCLES = 1;
  localparam int PHASE_W        = 3;   // Holds the longest phase count

  ////////////////////////////////////////
  // Startup display timing
  ////////////////////////////////////////
  localparam int DUTY_W         = 4;
  localparam int PAT_W          = 8;
  localparam int TABLE_DEPTH    = 32;
  localparam int STEP_CYCLES    = 64;  // Multiple of PAT_W
  localparam int DISPLAY_PASSES = 3;

  localparam int ROW_W  = $clog2(TABLE_DEPTH);
  localparam int STEP_W = $clog2(STEP_CYCLES);
  localparam int PASS_W = $clog2(DISPLAY_PASSES + 1);

endpackage

// File: design/bpi_top.sv
`timescale 1ns/1ns

module bpi_top (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic [bpi_pkg::ADDR_W-1:0]  addr_i,
  input  logic [bpi_pkg::DATA_W-1:0]  cmd_data_i,
  input  logic [bpi_pkg::OP_W-1:0]    op_i,
  input  logic                        execute_i,
  input  logic                        al_ena_i,
  input  logic [bpi_pkg::ADDR_W-1:0]  al_addr_i,
  input  logic [bpi_pkg::DATA_W-1:0]  al_cmd_data_i,
  input  logic [bpi_pkg::OP_W-1:0]    al_op_i,
  input  logic                        al_execute_i,
  input  logic                        run_i,
  input  logic                        bpi_active_i,
  input  logic [bpi_pkg::DATA_W-1:0]  status_i,
  output logic [bpi_pkg::DATA_W-1:0]  data_o,
  output logic                        load_data_o,
  output logic                        busy_o,
  output logic [bpi_pkg::ADDR_W-1:0]  bpi_ad_o,
  output logic                        fcs_b_o,
  output logic                        foe_b_o,
  output logic                        fwe_b_o,
  output logic                        flatch_b_o,
  inout  wire  [bpi_pkg::DATA_W-1:0]  cfg_dat_io
);
  import bpi_pkg::*;

  logic                     execute;
  logic                     read;
  logic                     write;
  logic                     capture;
  logic                     ce;
  logic                     latch;
  logic                     we;
  logic                     oe;
  logic                     load_pat;
  logic                     display;
  logic [DATA_W*DUTY_W-1:0] duty;
  logic [DATA_W-1:0]        leds;

  ////////////////////////////////////////
  // Flash path
  ////////////////////////////////////////
  bpi_port u_port (
    .CLK(CLK),
    .addr_i(addr_i), .cmd_data_i(cmd_data_i), .op_i(op_i), .execute_i(execute_i),
    .al_addr_i(al_addr_i), .al_cmd_data_i(al_cmd_data_i), .al_op_i(al_op_i),
    .al_execute_i(al_execute_i), .al_ena_i(al_ena_i),
    .bpi_active_i(bpi_active_i), .status_i(status_i),
    .leds_i(leds), .display_i(display), .capture_i(capture),
    .ce_i(ce), .latch_i(latch), .we_i(we), .oe_i(oe),
    .execute_o(execute), .read_o(read), .write_o(write),
    .data_o(data_o), .bpi_ad_o(bpi_ad_o),
    .fcs_b_o(fcs_b_o), .foe_b_o(foe_b_o), .fwe_b_o(fwe_b_o), .flatch_b_o(flatch_b_o),
    .cfg_dat_io(cfg_dat_io)
  );

  bpi_cycle_fsm u_fsm (
    .CLK(CLK), .RST(RST),
    .execute_i(execute), .read_i(read), .write_i(write),
    .capture_o(capture), .busy_o(busy_o), .load_o(load_data_o),
    .ce_o(ce), .latch_o(latch), .we_o(we), .oe_o(oe)
  );

  ////////////////////////////////////////
  // Startup display
  ////////////////////////////////////////
  led_sequencer u_seq (
    .CLK(CLK), .RST(RST), .run_i(run_i),
    .load_pat_o(load_pat), .duty_o(duty), .display_o(display)
  );

  for (genvar ch = 0; ch < DATA_W; ch++) begin : g_chan
    led_channel u_chan (
      .CLK(CLK), .RST(RST),
      .load_pat_i(load_pat),
      .duty_i(duty[ch*DUTY_W +: DUTY_W]),   // Own slice of the row
      .led_o(leds[ch])
    );
  end

endmodule

// File: display/led_channel.sv
`timescale 1ns/1ns

module led_channel (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        load_pat_i,
  input  logic [bpi_pkg::DUTY_W-1:0]  duty_i,
  output logic                        led_o
);
  import bpi_pkg::*;

  logic [PAT_W-1:0] thermo;
  logic [PAT_W-1:0] pat_q;

  // Level to low-aligned ones saturating at PAT_W
  always_comb begin
    for (int i = 0; i < PAT_W; i++) begin
      thermo[i] = (duty_i > i);
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      pat_q <= '0;
    end else if (load_pat_i) begin
      pat_q <= thermo;
    end else begin
      pat_q <= {pat_q[PAT_W-2:0], pat_q[PAT_W-1]};   // Rotate left
    end
  end

  assign led_o = pat_q[0];

endmodule

// File: display/led_patterns.hex
// One 64-bit duty word per row, 16 channels of 4 bits each
// Channel 0 is the rightmost digit, channel 15 the leftmost
fedcba9876543210
0fedcba987654321
10fedcba98765432
210fedcba9876543
3210fedcba987654
43210fedcba98765
543210fedcba9876
6543210fedcba987
76543210fedcba98
876543210fedcba9
9876543210fedcba
a9876543210fedcb
ba9876543210fedc
cba9876543210fed
dcba9876543210fe
edcba9876543210f
0123456789abcdef
123456789abcdef0
23456789abcdef01
3456789abcdef012
456789abcdef0123
56789abcdef01234
6789abcdef012345
789abcdef0123456
89abcdef01234567
9abcdef012345678
abcdef0123456789
bcdef0123456789a
cdef0123456789ab
def0123456789abc
ef0123456789abcd
f0123456789abcde

// File: display/led_sequencer.sv
`timescale 1ns/1ns

module led_sequencer (
  input  logic                                          CLK,
  input  logic                                          RST,
  input  logic                                          run_i,
  output logic                                          load_pat_o,
  output logic [bpi_pkg::DATA_W*bpi_pkg::DUTY_W-1:0]    duty_o,
  output logic                                          display_o
);
  import bpi_pkg::*;

  logic [DATA_W*DUTY_W-1:0] pat_table [0:TABLE_DEPTH-1];

  logic              display_q;
  logic [STEP_W-1:0] step_q;
  logic [ROW_W-1:0]  row_q;
  logic [PASS_W-1:0] pass_q;
  logic              step_end;
  logic              row_end;

  initial begin
    $readmemh("display/led_patterns.hex", pat_table);
  end

  assign step_end = (step_q == STEP_W'(STEP_CYCLES - 1));
  assign row_end  = (row_q == ROW_W'(TABLE_DEPTH - 1));

  ////////////////////////////////////////
  // Step, row and pass counters
  ////////////////////////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      display_q <= 1'b0;
      step_q    <= '0;
      row_q     <= '0;
      pass_q    <= '0;
    end else if (!display_q) begin
      if (run_i) begin              // Start of show
        display_q <= 1'b1;
        step_q    <= '0;
        row_q     <= '0;
        pass_q    <= '0;
      end
    end else begin
      step_q <= step_q + 1'b1;      // Wraps at STEP_CYCLES
      if (step_end) begin
        row_q <= row_q + 1'b1;
        if (row_end) begin
          pass_q <= pass_q + 1'b1;
          if (pass_q == PASS_W'(DISPLAY_PASSES - 1)) begin
            display_q <= 1'b0;      // Last pass done
          end
        end
      end
    end
  end

  // New row at the top of every step
  assign load_pat_o = display_q && (step_q == '0);
  assign duty_o     = pat_table[row_q];
  assign display_o  = display_q;

endmodule

// File: tb.f
common/bpi_pkg.sv
bpi/bpi_cycle_fsm.sv
bpi/bpi_port.sv
display/led_channel.sv
display/led_sequencer.sv
design/bpi_top.sv
tb/bpi_checker.sv
tb/bpi_top_sva.sv
tb/tb_bpi_top.sv

// File: tb/bpi_checker.sv
`timescale 1ns/1ns

module bpi_checker (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        busy_o,
  input  logic                        load_data_o,
  input  logic [bpi_pkg::DATA_W-1:0]  data_o,
  input  logic [bpi_pkg::ADDR_W-1:0]  bpi_ad_o,
  input  logic                        fcs_b_o,
  input  logic                        foe_b_o,
  input  logic                        fwe_b_o,
  input  logic                        flatch_b_o,
  input  logic [bpi_pkg::OP_W-1:0]    exp_op,
  input  logic [bpi_pkg::ADDR_W-1:0]  exp_addr,
  input  logic [bpi_pkg::DATA_W-1:0]  exp_word,
  input  logic                        pin_chk,
  input  logic [bpi_pkg::DATA_W-1:0]  exp_pins,
  input  logic                        test_end,
  input  int                          test_id,
  output int                          checks_o,
  output int                          errors_o
);
  import bpi_pkg::*;

  int n_checks = 0;
  int n_errors = 0;
  int test_errs = 0;
  int n_busy, n_ce, n_latch, n_we, n_oe, n_load;
  logic busy_q = 1'b0;
  logic [OP_W-1:0]   op_q;
  logic [DATA_W-1:0] word_q;
  bit   active, rd, wr;

  assign checks_o = n_checks;
  assign errors_o = n_errors;

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      $display("Fail at %0t: %s got %0h expected %0h", $time, name, got, exp);
      n_errors++;
      test_errs++;
    end
  endtask

  // Sampled on the rising edge, before the DUT registers update
  always @(posedge CLK) begin
    if (!RST) begin
      if (busy_o && !busy_q) begin            // New operation
        op_q = exp_op;
        word_q = exp_word;
        n_busy = 0;
        n_ce = 0;
        n_latch = 0;
        n_we = 0;
        n_oe = 0;
        n_load = 0;
        compare("bpi_ad_o", bpi_ad_o, exp_addr);
      end
      if (busy_o) begin
        n_busy++;
        if (!fcs_b_o) n_ce++;
        if (!flatch_b_o) n_latch++;
        if (!fwe_b_o) n_we++;
        if (!foe_b_o) n_oe++;
        if (load_data_o) n_load++;
      end
      if (!busy_o && busy_q) begin
        wr = (op_q == OP_WRITE);
        rd = (op_q == OP_READ);
        active = wr || rd;
        compare("busy_o high cycles", n_busy, active ? 7 : 1);
        compare("fcs_b_o low cycles", n_ce, active ? LATCH_CYCLES + ACCESS_CYCLES : 0);
        compare("flatch_b_o low cycles", n_latch, active ? LATCH_CYCLES : 0);
        compare("fwe_b_o low cycles", n_we, wr ? ACCESS_CYCLES : 0);
        compare("foe_b_o low cycles", n_oe, rd ? ACCESS_CYCLES : 0);
        compare("load_data_o pulses", n_load, rd ? 1 : 0);
      end
      if (load_data_o) compare("data_o", data_o, word_q);
      if (pin_chk) compare("data_o", data_o, exp_pins);
      busy_q = busy_o;
      if (test_end) begin
        $display("Test %0d %s with %0d errors", test_id,
                 (test_errs == 0) ? "passed" : "failed", test_errs);
        test_errs = 0;
      end
    end
  end

endmodule

// File: tb/bpi_top_sva.sv
`timescale 1ns/1ns

module bpi_top_sva (
  input logic CLK,
  input logic RST,
  input logic busy_o,
  input logic fcs_b_o,
  input logic foe_b_o,
  input logic fwe_b_o,
  input logic flatch_b_o
);
  import bpi_pkg::*;

  a_we_oe_excl: assert property (@(posedge CLK) disable iff (RST) fwe_b_o || foe_b_o)
    else $error("Write enable and output enable low together");

  // Latch opens the chip enable window and is released inside it
  a_latch_in_ce: assert property (@(posedge CLK) disable iff (RST)
    $fell(flatch_b_o) |->
      (!fcs_b_o && !flatch_b_o) [*LATCH_CYCLES] ##1 (!fcs_b_o && flatch_b_o))
    else $error("Address latch low outside chip enable");

  // Chip enable in the first busy cycle marks a real access
  a_busy_len: assert property (@(posedge CLK) disable iff (RST)
    $rose(busy_o) && !fcs_b_o |-> busy_o [*7] ##1 !busy_o)
    else $error("Busy length wrong for an access");

endmodule

bind bpi_top bpi_top_sva u_sva (.*);

// File: tb/tb_bpi_top.sv
`timescale 1ns/1ns

module tb_bpi_top;
  import bpi_pkg::*;

  localparam int FLASH_OPS   = 4 * 16 + 2;
  localparam int SHOW_CYCLES = STEP_CYCLES * TABLE_DEPTH * DISPLAY_PASSES;
  localparam int TEST_CYCLES = FLASH_OPS * 9 + SHOW_CYCLES + 40;
  localparam int CYCLE_LIMIT = TEST_CYCLES * 12 / 10;   // 20 percent margin

  logic CLK, RST;
  logic [ADDR_W-1:0] addr_i, al_addr_i;
  logic [DATA_W-1:0] cmd_data_i, al_cmd_data_i, status_i;
  logic [OP_W-1:0]   op_i, al_op_i;
  logic execute_i, al_ena_i, al_execute_i, run_i, bpi_active_i;
  logic [DATA_W-1:0] data_o;
  logic [ADDR_W-1:0] bpi_ad_o;
  logic load_data_o, busy_o, fcs_b_o, foe_b_o, fwe_b_o, flatch_b_o;
  wire  [DATA_W-1:0] cfg_dat_io;

  // Expectations handed to the checker
  logic [OP_W-1:0]   exp_op;
  logic [ADDR_W-1:0] exp_addr;
  logic [DATA_W-1:0] exp_word, exp_pins, last_data;
  logic pin_chk, test_end;
  int   test_id, checks, errors;

  logic [31:0] lfsr_q;
  logic [DATA_W*DUTY_W-1:0] ref_table [0:TABLE_DEPTH-1];
  logic [DATA_W-1:0] shadow [logic [ADDR_W-1:0]];
  logic [DATA_W-1:0] flash_mem [logic [ADDR_W-1:0]];
  logic [DATA_W-1:0] flash_rd;

  bpi_top dut (.*);

  bpi_checker chk (
    .CLK(CLK), .RST(RST), .busy_o(busy_o), .load_data_o(load_data_o), .data_o(data_o),
    .bpi_ad_o(bpi_ad_o),
    .fcs_b_o(fcs_b_o), .foe_b_o(foe_b_o), .fwe_b_o(fwe_b_o), .flatch_b_o(flatch_b_o),
    .exp_op(exp_op), .exp_addr(exp_addr), .exp_word(exp_word),
    .pin_chk(pin_chk), .exp_pins(exp_pins),
    .test_end(test_end), .test_id(test_id), .checks_o(checks), .errors_o(errors)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  ////////////////////////////////////////
  // Flash model
  ////////////////////////////////////////
  function automatic logic [DATA_W-1:0] fill_word(logic [ADDR_W-1:0] a);
    return a[15:0] ^ {a[22:16], a[22:14]};   // Blank contents per address
  endfunction

  always @(posedge fwe_b_o) begin
    if (!RST) flash_mem[bpi_ad_o] = cfg_dat_io;
  end

  always @(negedge foe_b_o) begin
    flash_rd = flash_mem.exists(bpi_ad_o) ? flash_mem[bpi_ad_o] : fill_word(bpi_ad_o);
  end

  assign cfg_dat_io = foe_b_o ? 'z : flash_rd;

  ////////////////////////////////////////
  // LFSR and reference
  ////////////////////////////////////////
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic logic [DATA_W-1:0] expected_read(logic [ADDR_W-1:0] a);
    return shadow.exists(a) ? shadow[a] : fill_word(a);
  endfunction

  // Pin value g cycles after the first row load
  function automatic logic [DATA_W-1:0] expected_leds(int g);
    logic [DUTY_W*DATA_W-1:0] row;
    int lvl, k;
    logic [DATA_W-1:0] w;
    row = ref_table[(g / STEP_CYCLES) % TABLE_DEPTH];
    k = g % PAT_W;
    for (int ch = 0; ch < DATA_W; ch++) begin
      lvl = row[ch*DUTY_W +: DUTY_W];
      if (lvl > PAT_W) lvl = PAT_W;
      w[ch] = (lvl > (PAT_W - k) % PAT_W);   // Bit 0 after k left turns
    end
    return w;
  endfunction

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  task automatic run_op(input bit use_al, input logic [OP_W-1:0] op,
                        input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
    @(negedge CLK);
    exp_op   = op;
    exp_addr = a;
    exp_word = expected_read(a);
    al_ena_i = use_al;
    al_addr_i = a;
    al_cmd_data_i = d;
    al_op_i = op;
    al_execute_i = use_al;
    addr_i = use_al ? ~a : a;                    // Decoy values while auto-load is on
    cmd_data_i = use_al ? ~d : d;
    op_i = (use_al && op == OP_WRITE) ? OP_READ : op;
    execute_i = 1'b1;
    if (op == OP_WRITE) shadow[a] = d;
    last_data = d;
    @(negedge CLK);
    execute_i = 1'b0;
    al_execute_i = 1'b0;
    while (busy_o === 1'b1) @(negedge CLK);
    al_ena_i = 1'b0;
  endtask

  task automatic finish_test(input int id);
    test_id  = id;
    test_end = 1'b1;
    @(negedge CLK);
    test_end = 1'b0;
  endtask

  initial begin
    logic [ADDR_W-1:0] addrs [16];
    logic [DATA_W-1:0] d;
    RST = 1'b1;
    addr_i = '0;
    cmd_data_i = '0;
    op_i = '0;
    execute_i = 1'b0;
    al_ena_i = 1'b0;
    al_addr_i = '0;
    al_cmd_data_i = '0;
    al_op_i = '0;
    al_execute_i = 1'b0;
    run_i = 1'b0;
    bpi_active_i = 1'b1;
    status_i = 16'hc35a;
    exp_op = '0;
    exp_addr = '0;
    exp_word = '0;
    exp_pins = '0;
    last_data = '0;
    pin_chk = 1'b0;
    test_end = 1'b0;
    test_id = 0;
    lfsr_q = 32'h28b6_9a1e;
    $readmemh("display/led_patterns.hex", ref_table);
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    for (int i = 0; i < 16; i++) begin
      addrs[i] = rand_bits(ADDR_W);
      run_op(1'b0, OP_WRITE, addrs[i], rand_bits(DATA_W));
    end
    for (int i = 0; i < 16; i++) run_op(1'b0, OP_READ, addrs[i], '0);
    finish_test(1);

    for (int i = 0; i < 16; i++) begin
      addrs[i] = rand_bits(ADDR_W);
      run_op(1'b1, OP_WRITE, addrs[i], rand_bits(DATA_W));
    end
    for (int i = 0; i < 16; i++) run_op(1'b0, OP_READ, addrs[i], '0);
    finish_test(2);

    run_op(1'b0, OP_STANDBY, rand_bits(ADDR_W), rand_bits(DATA_W));
    run_op(1'b0, 2'd3, rand_bits(ADDR_W), 16'h5a3c);
    finish_test(3);

    // Display show with the flash idle
    bpi_active_i = 1'b0;
    exp_pins = status_i;
    pin_chk  = 1'b1;
    run_i    = 1'b1;
    @(negedge CLK);
    run_i   = 1'b0;
    pin_chk = 1'b0;
    @(negedge CLK);
    for (int g = 0; g < SHOW_CYCLES - 1; g++) begin
      exp_pins = expected_leds(g);
      pin_chk  = 1'b1;
      @(negedge CLK);
    end
    exp_pins = status_i;
    finish_test(4);

    for (int i = 0; i < 4; i++) begin
      d = rand_bits(DATA_W);
      status_i = d;
      exp_pins = d;
      @(negedge CLK);
    end
    bpi_active_i = 1'b1;
    exp_pins = last_data;                        // Registered data takes the pins
    repeat (3) @(negedge CLK);
    pin_chk = 1'b0;
    finish_test(5);

    @(negedge CLK);
    $display("Tests: 5, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Run length guard
  initial begin
    int cycles;
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge CLK);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Finished with errors");
    $finish;
  end

endmodule
